//--- source/rdm_pkg.sv
/* Burst read master shared definitions
   Bus widths, burst geometry and the payload structs */

package rdm_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int SIZE_W  = 16;
  localparam int ARLEN_W = 8;

  //////////////////////////////////////////////////
  // Burst geometry
  //////////////////////////////////////////////////
  localparam int BEAT_BYTES  = DATA_W / 8;
  localparam int BEAT_BITS   = $clog2(BEAT_BYTES);
  // AXI4 limits a burst to 256 beats and to one 4 KB page
  localparam int BURST_BEATS = (4096 / BEAT_BYTES < 256) ? 4096 / BEAT_BYTES : 256;
  localparam int BURST_BITS  = $clog2(BURST_BEATS);
  localparam int BURST_BYTES = BURST_BEATS * BEAT_BYTES;
  localparam int BURST_CNT_W = SIZE_W - BEAT_BITS - BURST_BITS;

  // Start request, sampled on ctrl_start
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [SIZE_W-1:0] size;
  } ctrl_req_t;

  // AR channel payload, len is beats minus one
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    logic [ARLEN_W-1:0] len;
  } ar_req_t;

  // One data beat on R and on the stream
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } r_beat_t;

  // Burst split of one request
  typedef struct packed {
    logic [ADDR_W-1:0]      base;
    logic [BURST_CNT_W-1:0] bursts;     // Burst count minus one
    logic [ARLEN_W-1:0]     final_len;  // arlen of the last burst
  } burst_plan_t;

endpackage

//--- source/xfer_ctrl.sv
/* Transfer control for the burst read master
   Samples the request, splits it into bursts and flags completion */

`timescale 1ns/1ps

module xfer_ctrl (
  input  logic                 aclk,
  input  logic                 areset,
  input  logic                 ctrl_start,
  input  rdm_pkg::ctrl_req_t   ctrl_req,
  input  logic                 r_fire,
  input  logic                 r_last,
  output logic                 start,
  output rdm_pkg::burst_plan_t plan,
  output logic                 ctrl_done
);

  import rdm_pkg::*;

  // Beat count minus one
  localparam int TOTAL_W = SIZE_W - BEAT_BITS;

  ctrl_req_t              req_r;
  logic [1:0]             start_sr;
  logic [TOTAL_W-1:0]     len_r;
  logic [ADDR_W-1:0]      base_r;
  logic                   r_active;
  logic [BURST_CNT_W-1:0] r_left;

  //////////////////////////////////////////////////
  // Request pipeline
  //////////////////////////////////////////////////
  // Stage 1 holds the raw request
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      req_r <= ctrl_req;
    end
  end

  // Stage 2 rounds up to whole beats and aligns down to a burst
  always_ff @(posedge aclk) begin
    if (start_sr[0]) begin
      if (|req_r.size[BEAT_BITS-1:0]) begin
        len_r <= req_r.size[SIZE_W-1:BEAT_BITS];
      end else begin
        len_r <= req_r.size[SIZE_W-1:BEAT_BITS] - 1'b1;
      end
      base_r <= req_r.addr & ~ADDR_W'(BURST_BYTES - 1);
    end
  end

  // start comes two edges after the sampling edge
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_sr <= '0;
      start    <= 1'b0;
    end else begin
      start_sr <= {start_sr[0], ctrl_start};
      start    <= start_sr[1];
    end
  end

  // Upper bits count full bursts, low bits give the final arlen
  assign plan.base      = base_r;
  assign plan.bursts    = len_r[TOTAL_W-1:BURST_BITS];
  assign plan.final_len = len_r[BURST_BITS-1:0];

  //////////////////////////////////////////////////
  // Completion tracking on R
  //////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      r_active  <= 1'b0;
      r_left    <= '0;
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= 1'b0;
      if (start) begin
        r_active <= 1'b1;
        r_left   <= plan.bursts;
      end else if (r_active && r_fire && r_last) begin
        // Last beat of the final burst ends the request
        if (r_left == '0) begin
          r_active  <= 1'b0;
          ctrl_done <= 1'b1;
        end else begin
          r_left <= r_left - 1'b1;
        end
      end
    end
  end

endmodule

//--- source/ar_issuer.sv
/* AR channel issuer for the burst read master
   Walks the burst plan under an outstanding-burst credit limit */

`timescale 1ns/1ps

module ar_issuer #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                 aclk,
  input  logic                 areset,
  input  logic                 start,
  input  rdm_pkg::burst_plan_t plan,
  input  logic                 burst_popped,
  output logic                 arvalid,
  input  logic                 arready,
  output rdm_pkg::ar_req_t     ar
);

  import rdm_pkg::*;

  localparam int CREDIT_W = $clog2(MAX_OUTSTANDING + 1);

  logic                   idle;
  logic [ADDR_W-1:0]      addr;
  logic [BURST_CNT_W-1:0] ar_left;
  logic [CREDIT_W-1:0]    credit;
  logic                   ar_fire;
  logic                   ar_final;

  assign ar_fire  = arvalid & arready;
  // Zero bursts left means the one on the bus is the last
  assign ar_final = (ar_left == '0);

  //////////////////////////////////////////////////
  // Address walk
  //////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      idle    <= 1'b1;
      ar_left <= '0;
    end else if (start) begin
      idle    <= 1'b0;
      ar_left <= plan.bursts;
    end else if (ar_fire) begin
      if (ar_final) begin
        idle <= 1'b1;
      end else begin
        ar_left <= ar_left - 1'b1;
      end
    end
  end

  // Next burst starts one full burst further on
  always_ff @(posedge aclk) begin
    if (start) begin
      addr <= plan.base;
    end else if (ar_fire) begin
      addr <= addr + ADDR_W'(BURST_BYTES);
    end
  end

  //////////////////////////////////////////////////
  // Outstanding credit
  //////////////////////////////////////////////////
  // Taken on each AR, returned when the burst leaves the FIFO
  always_ff @(posedge aclk) begin
    if (areset) begin
      credit <= CREDIT_W'(MAX_OUTSTANDING);
    end else begin
      case ({ar_fire, burst_popped})
        2'b10:   credit <= credit - 1'b1;
        2'b01:   credit <= credit + 1'b1;
        default: credit <= credit;
      endcase
    end
  end

  // Hold arvalid until accepted, then at least one idle cycle
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (arvalid) begin
      arvalid <= ~arready;
    end else begin
      arvalid <= ~idle & (credit != '0);
    end
  end

  assign ar.addr = addr;
  assign ar.len  = ar_final ? plan.final_len : ARLEN_W'(BURST_BEATS - 1);

endmodule

//--- source/rd_data_fifo.sv
/* Read data FIFO, first word fall through
   Buffers R beats for every outstanding burst and feeds the stream */

`timescale 1ns/1ps

module rd_data_fifo #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             rvalid,
  output logic             rready,
  input  rdm_pkg::r_beat_t r,
  output logic             tvalid,
  input  logic             tready,
  output rdm_pkg::r_beat_t t,
  output logic             burst_popped
);

  import rdm_pkg::*;

  // Room for every burst the credit allows, power of two
  localparam int DEPTH = 2 ** $clog2(BURST_BEATS * MAX_OUTSTANDING);
  localparam int AW    = $clog2(DEPTH);

  r_beat_t     mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        empty;
  logic        pop;
  logic        load;

  assign empty = (wr_ptr == rd_ptr);
  assign pop   = tvalid & tready;
  // Refill the output register when it is free or being drained
  assign load  = ~empty & (~tvalid | pop);

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (rvalid && rready) begin
      mem[wr_ptr[AW-1:0]] <= r;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      rready <= 1'b0;
      wr_ptr <= '0;
    end else begin
      rready <= 1'b1;
      wr_ptr <= wr_ptr + (AW+1)'(rvalid & rready);
    end
  end

  //////////////////////////////////////////////////
  // Read side with output register
  //////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (load) begin
      t <= mem[rd_ptr[AW-1:0]];
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      tvalid <= 1'b0;
      rd_ptr <= '0;
    end else begin
      if (load) begin
        tvalid <= 1'b1;
      end else if (pop) begin
        tvalid <= 1'b0;
      end
      rd_ptr <= rd_ptr + (AW+1)'(load);
    end
  end

  // A burst leaves once its last beat is taken
  assign burst_popped = pop & t.last;

endmodule

//--- source/read_master_top.sv
/* Burst read master top level
   AXI4 read bursts in, AXI4-Stream out */

`timescale 1ns/1ps

module read_master_top #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic               aclk,
  input  logic               areset,
  // Control
  input  logic               ctrl_start,
  input  rdm_pkg::ctrl_req_t ctrl_req,
  output logic               ctrl_done,
  // AXI4 read address
  output logic               arvalid,
  input  logic               arready,
  output rdm_pkg::ar_req_t   ar,
  // AXI4 read data
  input  logic               rvalid,
  output logic               rready,
  input  rdm_pkg::r_beat_t   r,
  // AXI4-Stream out
  output logic               tvalid,
  input  logic               tready,
  output rdm_pkg::r_beat_t   t
);

  import rdm_pkg::*;

  logic        start;
  burst_plan_t plan;
  logic        burst_popped;
  logic        r_fire;

  // Accepted R beat
  assign r_fire = rvalid & rready;

  xfer_ctrl i_xfer_ctrl (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_req   (ctrl_req),
    .r_fire     (r_fire),
    .r_last     (r.last),
    .start      (start),
    .plan       (plan),
    .ctrl_done  (ctrl_done)
  );

  ar_issuer #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_ar_issuer (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .plan         (plan),
    .burst_popped (burst_popped),
    .arvalid      (arvalid),
    .arready      (arready),
    .ar           (ar)
  );

  rd_data_fifo #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_rd_data_fifo (
    .aclk         (aclk),
    .areset       (areset),
    .rvalid       (rvalid),
    .rready       (rready),
    .r            (r),
    .tvalid       (tvalid),
    .tready       (tready),
    .t            (t),
    .burst_popped (burst_popped)
  );

endmodule

//--- bench/axi_mem_model.sv
/* Behavioral AXI4 read slave
   Queues ARs and returns beats whose data is the beat's byte address */

`timescale 1ns/1ps

module axi_mem_model (
  input  logic             aclk,
  input  logic             areset,
  input  logic             arvalid,
  output logic             arready,
  input  rdm_pkg::ar_req_t ar,
  output logic             rvalid,
  input  logic             rready,
  output rdm_pkg::r_beat_t r
);

  import rdm_pkg::*;

  // Small AR queue, at most two bursts waiting
  localparam int QUEUE_DEPTH = 2;

  ar_req_t ar_q[$];
  int      beat;
  logic    in_reset;

  initial begin
    arready  = 1'b0;
    rvalid   = 1'b0;
    r        = '0;
    beat     = 0;
    in_reset = 1'b1;
  end

  always @(posedge aclk) begin
    in_reset = areset;
    if (areset) begin
      ar_q.delete();
      beat = 0;
    end else begin
      // Retire the beat just taken, the burst ends on its arlen
      if (rvalid && rready) begin
        if (beat == int'(ar_q[0].len)) begin
          void'(ar_q.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
      if (arvalid && arready) begin
        ar_q.push_back(ar);
      end
    end
    #1;
    arready = !in_reset && (ar_q.size() < QUEUE_DEPTH);
    // Roughly one cycle in four is a gap
    rvalid  = (ar_q.size() != 0) && ($urandom_range(99) >= 25);
    if (ar_q.size() != 0) begin
      r.data = ar_q[0].addr + DATA_W'(beat * BEAT_BYTES);
      r.last = (beat == int'(ar_q[0].len));
    end
  end

endmodule

//--- bench/read_master_sva.sv
/* Protocol assertions for the burst read master
   AR hold and alignment, short final burst, stream hold and the outstanding limit */

`timescale 1ns/1ps

module read_master_sva #(
  parameter int MAX_OUTSTANDING = 4
) (
  input logic             aclk,
  input logic             areset,
  input logic             ctrl_done,
  input logic             arvalid,
  input logic             arready,
  input rdm_pkg::ar_req_t ar,
  input logic             tvalid,
  input logic             tready,
  input rdm_pkg::r_beat_t t
);

  import rdm_pkg::*;

  // Bursts issued on AR and not yet ended on the stream
  int   in_flight;
  // Short burst accepted, request has no more AR to send
  logic short_seen;

  always_ff @(posedge aclk) begin
    if (areset) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(arvalid && arready) - int'(tvalid && tready && t.last);
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      short_seen <= 1'b0;
    end else if (arvalid && arready && ar.len != ARLEN_W'(BURST_BEATS - 1)) begin
      short_seen <= 1'b1;
    end else if (ctrl_done) begin
      short_seen <= 1'b0;
    end
  end

  ar_hold: assert property (@(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("AR request changed or dropped before arready");

  // Every burst starts on a 1 KB boundary
  ar_legal: assert property (@(posedge aclk) disable iff (areset)
    arvalid |-> (ar.addr[9:0] == '0))
    else $error("Illegal AR address alignment");

  // Only the final burst of a request may be short
  ar_short_last: assert property (@(posedge aclk) disable iff (areset)
    short_seen |-> !arvalid)
    else $error("AR issued after a short burst of the same request");

  t_hold: assert property (@(posedge aclk) disable iff (areset)
    tvalid && !tready |=> tvalid && $stable(t))
    else $error("Stream beat changed while waiting for tready");

  outstanding: assert property (@(posedge aclk) disable iff (areset)
    in_flight <= MAX_OUTSTANDING)
    else $error("More bursts in flight than the outstanding limit");

endmodule

bind read_master_top read_master_sva #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_read_master_sva (
  .aclk      (aclk),
  .areset    (areset),
  .ctrl_done (ctrl_done),
  .arvalid   (arvalid),
  .arready   (arready),
  .ar        (ar),
  .tvalid    (tvalid),
  .tready    (tready),
  .t         (t)
);

//--- bench/tb_read_master.sv
/* Testbench for the burst read master
   Runs a request table and checks AR bursts, stream beats and done */

`timescale 1ns/1ps

module tb_read_master;

  import rdm_pkg::*;

  localparam int MAX_OUTSTANDING = 4;
  localparam int SEED            = 61759;
  localparam int RESET_CYCLES    = 4;

  // One request with its beat count and tready stall chance in percent
  typedef struct {
    ctrl_req_t req;
    int        beats;
    int        stall_pct;
  } entry_t;

  logic      aclk;
  logic      areset;
  logic      ctrl_start;
  ctrl_req_t ctrl_req;
  logic      ctrl_done;
  logic      arvalid;
  logic      arready;
  ar_req_t   ar;
  logic      rvalid;
  logic      rready;
  r_beat_t   r;
  logic      tvalid;
  logic      tready;
  r_beat_t   t;

  entry_t            table_q[$];
  logic [ADDR_W-1:0] cur_base;
  int                cur_beats;
  int                cur_stall_pct;
  int                beat_idx;
  int                ar_idx;
  int                r_count;
  int                done_count;
  int                in_flight;
  int                stall_left;
  int                cycles;
  int                cycle_limit;

  read_master_top #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_dut (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_req   (ctrl_req),
    .ctrl_done  (ctrl_done),
    .arvalid    (arvalid),
    .arready    (arready),
    .ar         (ar),
    .rvalid     (rvalid),
    .rready     (rready),
    .r          (r),
    .tvalid     (tvalid),
    .tready     (tready),
    .t          (t)
  );

  axi_mem_model i_mem (
    .aclk    (aclk),
    .areset  (areset),
    .arvalid (arvalid),
    .arready (arready),
    .ar      (ar),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r)
  );

  initial aclk = 1'b0;
  always #4 aclk = ~aclk;

  //////////////////////////////////////////////////
  // Error handling and compare tasks
  //////////////////////////////////////////////////
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_beat(input r_beat_t got, input r_beat_t exp, input string name);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s got data=%h last=%b, expected data=%h last=%b",
                              $time, name, got.data, got.last, exp.data, exp.last));
    end
  endtask

  task automatic check_ar(input ar_req_t got, input ar_req_t exp, input string name);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s got addr=%h len=%0d, expected addr=%h len=%0d",
                              $time, name, got.addr, got.len, exp.addr, exp.len));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    if (got != exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s got %0d, expected %0d",
                              $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////
  // Beat i reads base + 4i, last on each 256th beat and on the final one
  function automatic r_beat_t beat_expected(input int i);
    r_beat_t b;
    b.data = cur_base + ADDR_W'(i * 4);
    b.last = ((i + 1) % 256 == 0) || (i == cur_beats - 1);
    return b;
  endfunction

  // Burst k starts 1 KB further on, only the last one is short
  function automatic ar_req_t ar_expected(input int k);
    ar_req_t a;
    int      left;
    left   = cur_beats - 256 * k;
    a.addr = cur_base + ADDR_W'(1024 * k);
    a.len  = (left >= 256) ? 8'd255 : 8'(left - 1);
    return a;
  endfunction

  task automatic add_entry(input logic [ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size,
                           input int beats, input int stall_pct);
    entry_t e;
    e.req.addr  = addr;
    e.req.size  = size;
    e.beats     = beats;
    e.stall_pct = stall_pct;
    table_q.push_back(e);
  endtask

  //////////////////////////////////////////////////
  // Monitor, timeout and stream back-pressure
  //////////////////////////////////////////////////
  always @(posedge aclk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      stop_on_error($sformatf("Timeout: no completion within %0d cycles", cycle_limit));
    end
    if (!areset) begin
      if (arvalid && arready) begin
        check_ar(ar, ar_expected(ar_idx), "ar");
        ar_idx++;
        in_flight++;
      end
      if (rvalid && rready) begin
        r_count++;
      end
      if (tvalid && tready) begin
        if (beat_idx >= cur_beats) begin
          stop_on_error("Stream delivered more beats than the request holds");
        end
        check_beat(t, beat_expected(beat_idx), "t");
        beat_idx++;
        in_flight -= int'(t.last);
      end
      if (in_flight > MAX_OUTSTANDING) begin
        stop_on_error("More bursts in flight than the outstanding limit");
      end
      // All R beats must be in before done
      if (ctrl_done) begin
        done_count++;
        check_count(r_count, cur_beats, "R beats at ctrl_done");
      end
    end
  end

  // Stalls of up to 100 cycles start at random
  always @(posedge aclk) begin
    #1;
    if (stall_left > 0) begin
      tready = 1'b0;
      stall_left--;
    end else if ($urandom_range(99) < cur_stall_pct) begin
      tready     = 1'b0;
      stall_left = $urandom_range(100);
    end else begin
      tready = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Request table loop
  //////////////////////////////////////////////////
  initial begin
    int bursts;
    void'($urandom(SEED));
    areset        = 1'b1;
    ctrl_start    = 1'b0;
    ctrl_req      = '0;
    tready        = 1'b0;
    cur_base      = '0;
    cur_beats     = 0;
    cur_stall_pct = 0;
    beat_idx      = 0;
    ar_idx        = 0;
    r_count       = 0;
    done_count    = 0;
    in_flight     = 0;
    stall_left    = 0;
    cycles        = 0;
    // Aligned small, unaligned odd size, one burst, two bursts,
    // seven bursts under stalls, unaligned long, single byte
    add_entry(32'h0000_1000, 16'd64,   16,   0);
    add_entry(32'h0000_2123, 16'd30,   8,    10);
    add_entry(32'h0001_0000, 16'd1024, 256,  2);
    add_entry(32'h0002_0400, 16'd1025, 257,  0);
    add_entry(32'h0010_0000, 16'd6146, 1537, 4);
    add_entry(32'h0030_07fc, 16'd5000, 1250, 0);
    add_entry(32'h0040_0ffd, 16'd1,    1,    0);
    cycle_limit = 100;
    foreach (table_q[i]) begin
      cycle_limit += table_q[i].beats * (2 + table_q[i].stall_pct) + 400;
    end

    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    areset = 1'b0;
    @(posedge aclk);
    #1;
    check_count(int'(arvalid), 0, "arvalid after reset");
    check_count(int'(tvalid), 0, "tvalid after reset");
    check_count(int'(ctrl_done), 0, "ctrl_done after reset");
    check_count(int'(rready), 1, "rready after reset");

    foreach (table_q[i]) begin
      bursts        = (table_q[i].beats + 255) / 256;
      cur_base      = (table_q[i].req.addr / 32'd1024) * 32'd1024;
      cur_beats     = table_q[i].beats;
      cur_stall_pct = table_q[i].stall_pct;
      beat_idx      = 0;
      ar_idx        = 0;
      r_count       = 0;
      done_count    = 0;
      ctrl_req      = table_q[i].req;
      ctrl_start    = 1'b1;
      @(posedge aclk);
      #1;
      ctrl_start = 1'b0;
      // Done seen and the stream drained
      do begin
        @(posedge aclk);
        #1;
      end while (!(done_count > 0 && beat_idx == cur_beats && !tvalid));
      // Quiet cycles catch a late extra beat or done pulse
      repeat (8) @(posedge aclk);
      #1;
      check_count(done_count, 1, "ctrl_done pulses");
      check_count(ar_idx, bursts, "AR bursts");
      check_count(r_count, cur_beats, "R beats");
      check_count(in_flight, 0, "bursts in flight");
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- src.f
source/rdm_pkg.sv
source/xfer_ctrl.sv
source/ar_issuer.sv
source/rd_data_fifo.sv
source/read_master_top.sv
bench/axi_mem_model.sv
bench/read_master_sva.sv
bench/tb_read_master.sv

//--- Makefile
# Verilator build and run of the burst read master testbench

VERILATOR ?= verilator
TOP       ?= tb_read_master
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_STR)' $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
